// ==== logic/bank_macros.svh ====
`ifndef BANK_MACROS_SVH
`define BANK_MACROS_SVH

// word and line geometry
`define BANK_WORD_W          32
`define BANK_WORDS_PER_LINE  4
`define BANK_WSEL_W          2
`define BANK_BYTEEN_W        4

// line address split, index low and tag high
`define BANK_INDEX_W         6
`define BANK_TAG_W           4
`define BANK_LINE_ADDR_W     (`BANK_INDEX_W + `BANK_TAG_W)

// miss tracking and request ids
`define BANK_MSHR_SIZE       4
`define BANK_MSHR_ID_W       2
`define BANK_CORE_TAG_W      8

// queue depths
`define BANK_CREQ_DEPTH      4
`define BANK_CRSQ_DEPTH      4
`define BANK_MREQ_DEPTH      4
`define BANK_MREQ_ALM_FULL   (`BANK_MREQ_DEPTH - 2)

`endif

// ==== logic/bank_pkg.sv ====
`default_nettype none

`include "bank_macros.svh"

package bank_pkg;

    typedef logic [`BANK_WORD_W-1:0]                      word_t;
    typedef logic [`BANK_WORD_W*`BANK_WORDS_PER_LINE-1:0] line_t;
    typedef logic [`BANK_LINE_ADDR_W-1:0]                 line_addr_t;
    typedef logic [`BANK_WSEL_W-1:0]                      wsel_t;
    typedef logic [`BANK_BYTEEN_W-1:0]                    byteen_t;
    typedef logic [`BANK_MSHR_ID_W-1:0]                   mshr_id_t;
    typedef logic [`BANK_CORE_TAG_W-1:0]                  core_tag_t;

    // operation carried down the pipeline
    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_fill,
        op_replay
    } bank_op_e;

endpackage

`default_nettype wire

// ==== logic/bank_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module bank_fifo #(
    parameter int DATA_W   = 8,
    parameter int DEPTH    = 4,
    parameter int ALM_FULL = DEPTH - 1
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               push,
    input  wire               pop,
    input  wire  [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic              empty,
    output logic              full,
    output logic              alm_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    // overflow and underflow are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign alm_full = (count >= CNT_W'(ALM_FULL));

endmodule

`default_nettype wire

// ==== logic/bank_tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bank_macros.svh"

module bank_tag_store (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       stall,
    input  wire                       lookup,
    input  wire                       fill,
    input  wire bank_pkg::line_addr_t addr,
    output logic                      tag_match
);

    localparam int LINES = 2 ** `BANK_INDEX_W;

    logic [LINES-1:0]         valid;
    logic [`BANK_TAG_W-1:0]   tags [LINES];
    logic [`BANK_INDEX_W-1:0] index;
    logic [`BANK_TAG_W-1:0]   tag;

    assign index = addr[`BANK_INDEX_W-1:0];
    assign tag   = addr[`BANK_LINE_ADDR_W-1:`BANK_INDEX_W];

    // match is held while stage 0 is frozen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid     <= '0;
            tag_match <= 1'b0;
        end else if (!stall) begin
            if (fill) begin
                valid[index] <= 1'b1;
            end
            tag_match <= lookup && valid[index] && (tags[index] == tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill && !stall) begin
            tags[index] <= tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/bank_data_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bank_macros.svh"

module bank_data_store (
    input  wire                       clk,
    input  wire                       stall,
    input  wire                       read,
    input  wire                       fill,
    input  wire                       write,
    input  wire bank_pkg::line_addr_t addr,
    input  wire bank_pkg::wsel_t      wsel,
    input  wire bank_pkg::byteen_t    byteen,
    input  wire bank_pkg::line_t      fill_data,
    input  wire bank_pkg::word_t      write_data,
    output bank_pkg::word_t           read_data
);

    import bank_pkg::*;

    localparam int LINES  = 2 ** `BANK_INDEX_W;
    localparam int BYTE_W = `BANK_WORD_W / `BANK_BYTEEN_W;

    line_t                    lines [LINES];
    logic [`BANK_INDEX_W-1:0] index;
    line_t                    cur_line;
    word_t                    cur_word;
    word_t                    merged;

    assign index    = addr[`BANK_INDEX_W-1:0];
    assign cur_line = lines[index];
    assign cur_word = cur_line[wsel*`BANK_WORD_W +: `BANK_WORD_W];

    // only the enabled bytes change
    always_comb begin
        merged = cur_word;
        for (int b = 0; b < `BANK_BYTEEN_W; b++) begin
            if (byteen[b]) begin
                merged[b*BYTE_W +: BYTE_W] = write_data[b*BYTE_W +: BYTE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (fill) begin
                lines[index] <= fill_data;
            end else if (write) begin
                lines[index][wsel*`BANK_WORD_W +: `BANK_WORD_W] <= merged;
            end
            if (read) begin
                read_data <= cur_word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bank_mshr.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bank_macros.svh"

module bank_mshr (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       allocate,
    input  wire bank_pkg::line_addr_t alloc_addr,
    input  wire bank_pkg::wsel_t      alloc_wsel,
    input  wire bank_pkg::core_tag_t  alloc_tag,
    input  wire                       fill_valid,
    input  wire bank_pkg::mshr_id_t   fill_id,
    input  wire                       replay_ready,
    input  wire                       release_valid,
    input  wire bank_pkg::mshr_id_t   release_id,
    output bank_pkg::mshr_id_t        alloc_id,
    output bank_pkg::line_addr_t      fill_addr,
    output logic                      replay_valid,
    output bank_pkg::mshr_id_t        replay_id,
    output bank_pkg::line_addr_t      replay_addr,
    output bank_pkg::wsel_t           replay_wsel,
    output bank_pkg::core_tag_t       replay_tag,
    output logic                      alm_full
);

    import bank_pkg::*;

    localparam int CNT_W = $clog2(`BANK_MSHR_SIZE + 1);

    line_addr_t                 addr_q [`BANK_MSHR_SIZE];
    wsel_t                      wsel_q [`BANK_MSHR_SIZE];
    core_tag_t                  tag_q  [`BANK_MSHR_SIZE];
    logic [`BANK_MSHR_SIZE-1:0] busy;
    logic [`BANK_MSHR_SIZE-1:0] ready;
    logic [CNT_W-1:0]           count;
    logic                       replay_fire;

    // lowest free entry and lowest entry waiting for replay
    always_comb begin
        alloc_id  = '0;
        replay_id = '0;
        for (int i = `BANK_MSHR_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_id = mshr_id_t'(i);
            end
            if (ready[i]) begin
                replay_id = mshr_id_t'(i);
            end
        end
    end

    assign replay_valid = |ready;
    assign replay_fire  = replay_valid && replay_ready;
    assign replay_addr  = addr_q[replay_id];
    assign replay_wsel  = wsel_q[replay_id];
    assign replay_tag   = tag_q[replay_id];
    assign fill_addr    = addr_q[fill_id];

    // one slot kept back for the read already on its way into stage 0
    assign alm_full = (count >= CNT_W'(`BANK_MSHR_SIZE - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= '0;
            ready <= '0;
            count <= '0;
        end else begin
            if (allocate) begin
                busy[alloc_id] <= 1'b1;
            end
            if (fill_valid) begin
                ready[fill_id] <= 1'b1;
            end
            if (replay_fire) begin
                busy[replay_id]  <= 1'b0;
                ready[replay_id] <= 1'b0;
            end
            // hit in stage 1 gives its entry back
            if (release_valid) begin
                busy[release_id] <= 1'b0;
            end
            count <= count + CNT_W'(allocate) - CNT_W'(replay_fire) - CNT_W'(release_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            addr_q[alloc_id] <= alloc_addr;
            wsel_q[alloc_id] <= alloc_wsel;
            tag_q[alloc_id]  <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bank_macros.svh"

module cache_bank (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       core_req_valid,
    input  wire                       core_req_rw,
    input  wire bank_pkg::line_addr_t core_req_addr,
    input  wire bank_pkg::wsel_t      core_req_wsel,
    input  wire bank_pkg::byteen_t    core_req_byteen,
    input  wire bank_pkg::word_t      core_req_data,
    input  wire bank_pkg::core_tag_t  core_req_tag,
    output wire                       core_req_ready,
    output wire                       core_rsp_valid,
    output wire bank_pkg::word_t      core_rsp_data,
    output wire bank_pkg::core_tag_t  core_rsp_tag,
    input  wire                       core_rsp_ready,
    output wire                       mem_req_valid,
    output wire                       mem_req_rw,
    output wire bank_pkg::line_addr_t mem_req_addr,
    output wire bank_pkg::mshr_id_t   mem_req_id,
    output wire bank_pkg::wsel_t      mem_req_wsel,
    output wire bank_pkg::byteen_t    mem_req_byteen,
    output wire bank_pkg::word_t      mem_req_data,
    input  wire                       mem_req_ready,
    input  wire                       mem_rsp_valid,
    input  wire bank_pkg::mshr_id_t   mem_rsp_id,
    input  wire bank_pkg::line_t      mem_rsp_data,
    output wire                       mem_rsp_ready
);

    import bank_pkg::*;

    localparam int CREQ_W = 1 + `BANK_LINE_ADDR_W + `BANK_WSEL_W + `BANK_BYTEEN_W
                          + `BANK_WORD_W + `BANK_CORE_TAG_W;
    localparam int CRSQ_W = `BANK_WORD_W + `BANK_CORE_TAG_W;
    localparam int MREQ_W = 1 + `BANK_LINE_ADDR_W + `BANK_MSHR_ID_W + `BANK_WSEL_W
                          + `BANK_BYTEEN_W + `BANK_WORD_W;

    logic       creq_full;
    logic       creq_empty;
    logic       creq_rw;
    line_addr_t creq_addr;
    wsel_t      creq_wsel;
    byteen_t    creq_byteen;
    word_t      creq_data;
    core_tag_t  creq_tag;
    logic       creq_fire;

    mshr_id_t   alloc_id;
    line_addr_t fill_addr;
    logic       replay_valid;
    logic       replay_ready;
    line_addr_t replay_addr;
    wsel_t      replay_wsel;
    core_tag_t  replay_tag;
    logic       mshr_alm_full;

    logic       stall;
    logic       fill_fire;
    logic       sel_valid;
    bank_op_e   sel_op;
    line_addr_t sel_addr;

    logic       valid_st0;
    bank_op_e   op_st0;
    line_addr_t addr_st0;
    wsel_t      wsel_st0;
    byteen_t    byteen_st0;
    word_t      wdata_st0;
    core_tag_t  tag_st0;
    line_t      line_st0;
    logic       tag_match_st0;
    logic       miss_st0;

    logic       valid_st1;
    bank_op_e   op_st1;
    logic       miss_st1;
    line_addr_t addr_st1;
    wsel_t      wsel_st1;
    byteen_t    byteen_st1;
    word_t      wdata_st1;
    core_tag_t  tag_st1;
    mshr_id_t   mshr_id_st1;
    word_t      rdata_st1;
    logic       rd_hit_st1;

    logic       crsq_valid;
    logic       crsq_full;
    logic       crsq_empty;
    logic       mreq_push;
    logic       mreq_empty;
    logic       mreq_alm_full;

    bank_fifo #(
        .DATA_W (CREQ_W),
        .DEPTH  (`BANK_CREQ_DEPTH)
    ) core_req_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (core_req_valid && !creq_full),
        .pop      (creq_fire),
        .data_in  ({core_req_rw, core_req_addr, core_req_wsel, core_req_byteen,
                    core_req_data, core_req_tag}),
        .data_out ({creq_rw, creq_addr, creq_wsel, creq_byteen, creq_data, creq_tag}),
        .empty    (creq_empty),
        .full     (creq_full),
        .alm_full ()
    );

    assign core_req_ready = !creq_full;

    // fixed priority: replay, fill, core request
    assign replay_ready  = !stall && !(valid_st0 && op_st0 == op_fill);
    assign mem_rsp_ready = !replay_valid && !stall;
    assign fill_fire     = mem_rsp_valid && mem_rsp_ready;
    assign creq_fire     = !creq_empty && !replay_valid && !mem_rsp_valid && !stall
                         && !mreq_alm_full && !mshr_alm_full
                         && !(!creq_rw && valid_st0 && op_st0 == op_write);

    assign sel_valid = (replay_valid && replay_ready) || fill_fire || creq_fire;
    assign sel_op    = replay_valid  ? op_replay :
                       mem_rsp_valid ? op_fill   :
                       creq_rw       ? op_write  : op_read;
    assign sel_addr  = replay_valid  ? replay_addr :
                       mem_rsp_valid ? fill_addr   : creq_addr;

    bank_tag_store tag_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .lookup    (creq_fire),
        .fill      (fill_fire),
        .addr      (sel_addr),
        .tag_match (tag_match_st0)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!stall) begin
            valid_st0 <= sel_valid;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            op_st0      <= sel_op;
            addr_st0    <= sel_addr;
            wsel_st0    <= replay_valid ? replay_wsel : creq_wsel;
            tag_st0     <= replay_valid ? replay_tag : creq_tag;
            byteen_st0  <= creq_byteen;
            wdata_st0   <= creq_data;
            line_st0    <= mem_rsp_data;
            op_st1      <= op_st0;
            miss_st1    <= miss_st0;
            addr_st1    <= addr_st0;
            wsel_st1    <= wsel_st0;
            byteen_st1  <= byteen_st0;
            wdata_st1   <= wdata_st0;
            tag_st1     <= tag_st0;
            mshr_id_st1 <= alloc_id;
        end
    end

    assign miss_st0 = (op_st0 == op_read || op_st0 == op_write) && !tag_match_st0;

    bank_data_store data_store (
        .clk        (clk),
        .stall      (stall),
        .read       (valid_st0 && (op_st0 == op_read || op_st0 == op_replay)),
        .fill       (valid_st0 && op_st0 == op_fill),
        .write      (valid_st0 && op_st0 == op_write && tag_match_st0),
        .addr       (addr_st0),
        .wsel       (wsel_st0),
        .byteen     (byteen_st0),
        .fill_data  (line_st0),
        .write_data (wdata_st0),
        .read_data  (rdata_st1)
    );

    // every core read takes an entry, hits hand it back in stage 1
    bank_mshr mshr (
        .clk           (clk),
        .arst_n        (arst_n),
        .allocate      (valid_st0 && op_st0 == op_read && !stall),
        .alloc_addr    (addr_st0),
        .alloc_wsel    (wsel_st0),
        .alloc_tag     (tag_st0),
        .fill_valid    (fill_fire),
        .fill_id       (mem_rsp_id),
        .replay_ready  (replay_ready),
        .release_valid (rd_hit_st1 && !stall),
        .release_id    (mshr_id_st1),
        .alloc_id      (alloc_id),
        .fill_addr     (fill_addr),
        .replay_valid  (replay_valid),
        .replay_id     (),
        .replay_addr   (replay_addr),
        .replay_wsel   (replay_wsel),
        .replay_tag    (replay_tag),
        .alm_full      (mshr_alm_full)
    );

    // read hits and replays answer the core
    assign rd_hit_st1 = valid_st1 && op_st1 == op_read && !miss_st1;
    assign crsq_valid = rd_hit_st1 || (valid_st1 && op_st1 == op_replay);
    assign stall      = crsq_valid && crsq_full;

    bank_fifo #(
        .DATA_W (CRSQ_W),
        .DEPTH  (`BANK_CRSQ_DEPTH)
    ) core_rsp_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (crsq_valid && !crsq_full),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_in  ({rdata_st1, tag_st1}),
        .data_out ({core_rsp_data, core_rsp_tag}),
        .empty    (crsq_empty),
        .full     (crsq_full),
        .alm_full ()
    );

    assign core_rsp_valid = !crsq_empty;

    // read misses and all writes go out to memory
    assign mreq_push = valid_st1 && ((op_st1 == op_read && miss_st1) || op_st1 == op_write);

    bank_fifo #(
        .DATA_W   (MREQ_W),
        .DEPTH    (`BANK_MREQ_DEPTH),
        .ALM_FULL (`BANK_MREQ_ALM_FULL)
    ) mem_req_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (mreq_push),
        .pop      (mem_req_valid && mem_req_ready),
        .data_in  ({op_st1 == op_write, addr_st1, mshr_id_st1, wsel_st1, byteen_st1,
                    wdata_st1}),
        .data_out ({mem_req_rw, mem_req_addr, mem_req_id, mem_req_wsel, mem_req_byteen,
                    mem_req_data}),
        .empty    (mreq_empty),
        .full     (),
        .alm_full (mreq_alm_full)
    );

    assign mem_req_valid = !mreq_empty;

endmodule

`default_nettype wire

// ==== verif/cache_bank_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_bank_tb;

    import bank_pkg::*;

    localparam int REQ_TIMEOUT   = 2000;
    localparam int RSP_TIMEOUT   = 4000;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int RANDOM_REQS   = 300;

    logic       clk;
    logic       arst_n;
    logic       core_req_valid;
    logic       core_req_rw;
    line_addr_t core_req_addr;
    wsel_t      core_req_wsel;
    byteen_t    core_req_byteen;
    word_t      core_req_data;
    core_tag_t  core_req_tag;
    logic       core_req_ready;
    logic       core_rsp_valid;
    word_t      core_rsp_data;
    core_tag_t  core_rsp_tag;
    logic       core_rsp_ready;
    logic       mem_req_valid;
    logic       mem_req_rw;
    line_addr_t mem_req_addr;
    mshr_id_t   mem_req_id;
    wsel_t      mem_req_wsel;
    byteen_t    mem_req_byteen;
    word_t      mem_req_data;
    logic       mem_req_ready;
    logic       mem_rsp_valid;
    mshr_id_t   mem_rsp_id;
    line_t      mem_rsp_data;
    logic       mem_rsp_ready;

    integer     seed;
    string      test_name;
    logic       rsp_backpressure;
    core_tag_t  next_tag;

    // contents as the core sees them, and memory as it really is
    word_t       ref_mem   [int];
    word_t       mem_model [int];

    // outstanding reads by core tag, writes still on their way to memory
    word_t       exp_word [int];
    line_addr_t  exp_addr [int];
    logic [47:0] exp_wr   [$];

    // memory reads waiting for their response
    mshr_id_t    pend_id   [$];
    line_t       pend_line [$];
    int          pend_wait [$];
    int          mem_reads;
    line_addr_t  last_read_addr;

    cache_bank UUT (.*);

    always #20 clk = ~clk;

    function automatic word_t pattern_word(input line_addr_t addr, input wsel_t wsel);
        return (32'(addr) * 32'd4 + 32'(wsel)) ^ 32'h1234_0000;
    endfunction

    function automatic int word_key(input line_addr_t addr, input wsel_t wsel);
        return int'({addr, wsel});
    endfunction

    function automatic word_t ref_read(input line_addr_t addr, input wsel_t wsel);
        int key;
        key = word_key(addr, wsel);
        return ref_mem.exists(key) ? ref_mem[key] : pattern_word(addr, wsel);
    endfunction

    function automatic word_t model_read(input line_addr_t addr, input wsel_t wsel);
        int key;
        key = word_key(addr, wsel);
        return mem_model.exists(key) ? mem_model[key] : pattern_word(addr, wsel);
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input byteen_t be);
        word_t res;
        int    b;
        res = old;
        for (b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic core_tag_t free_tag();
        core_tag_t t;
        t = next_tag;
        while (exp_word.exists(int'(t))) begin
            t = t + 1'b1;
        end
        next_tag = t + 1'b1;
        return t;
    endfunction

    // writes must not overtake a read of the same line still in flight
    function automatic logic line_busy(input line_addr_t addr);
        logic busy;
        busy = 1'b0;
        foreach (exp_addr[t]) begin
            if (exp_addr[t] == addr) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string check, input logic [63:0] expected,
                                   input logic [63:0] actual);
        abort_run($sformatf("Error: %s %s expected %0h actual %0h", test_name, check,
                            expected, actual));
    endtask

    task automatic send_req(input logic rw, input line_addr_t addr, input wsel_t wsel,
                            input byteen_t be, input word_t data, input core_tag_t tag);
        int cycles;
        cycles = 0;
        @(posedge clk);
        core_req_valid  <= 1'b1;
        core_req_rw     <= rw;
        core_req_addr   <= addr;
        core_req_wsel   <= wsel;
        core_req_byteen <= be;
        core_req_data   <= data;
        core_req_tag    <= tag;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                abort_run("timeout waiting for core_req_ready");
            end
        end while (!core_req_ready);
        core_req_valid <= 1'b0;
        if (rw) begin
            ref_mem[word_key(addr, wsel)] = merge_bytes(ref_read(addr, wsel), data, be);
            exp_wr.push_back({addr, wsel, be, data});
        end else begin
            exp_word[int'(tag)] = ref_read(addr, wsel);
            exp_addr[int'(tag)] = addr;
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (exp_word.size() != 0 || exp_wr.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("timeout in %s with %0d reads and %0d writes outstanding",
                                    test_name, exp_word.size(), exp_wr.size()));
            end
        end
    endtask

    always @(posedge clk) begin : check_responses
        if (arst_n && core_rsp_valid && core_rsp_ready) begin
            assert (exp_word.exists(int'(core_rsp_tag)))
            else abort_run($sformatf("response with tag %0h that is not outstanding",
                                     core_rsp_tag));
            assert (core_rsp_data == exp_word[int'(core_rsp_tag)])
            else report_mismatch($sformatf("read data tag %0h", core_rsp_tag),
                                 exp_word[int'(core_rsp_tag)], core_rsp_data);
            exp_word.delete(int'(core_rsp_tag));
            exp_addr.delete(int'(core_rsp_tag));
        end
    end

    // memory model plus random ready on both outputs
    always @(posedge clk) begin : environment
        logic [47:0] got;
        line_t       line;
        int          pick;
        int          i;
        if (arst_n) begin
            mem_req_ready  <= ($unsigned($random(seed)) % 4) != 0;
            core_rsp_ready <= rsp_backpressure ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_rw) begin
                    got = {mem_req_addr, mem_req_wsel, mem_req_byteen, mem_req_data};
                    assert (exp_wr.size() != 0)
                    else abort_run("memory write with no core write behind it");
                    assert (got == exp_wr[0])
                    else report_mismatch("memory write", exp_wr[0], got);
                    void'(exp_wr.pop_front());
                    mem_model[word_key(mem_req_addr, mem_req_wsel)] =
                        merge_bytes(model_read(mem_req_addr, mem_req_wsel), mem_req_data,
                                    mem_req_byteen);
                end else begin
                    for (i = 0; i < 4; i++) begin
                        line[i*32 +: 32] = model_read(mem_req_addr, wsel_t'(i));
                    end
                    pend_id.push_back(mem_req_id);
                    pend_line.push_back(line);
                    pend_wait.push_back(1 + $unsigned($random(seed)) % 12);
                    mem_reads++;
                    last_read_addr = mem_req_addr;
                end
            end
            for (i = 0; i < pend_wait.size(); i++) begin
                if (pend_wait[i] > 0) begin
                    pend_wait[i]--;
                end
            end
            // oldest expired entry goes next
            if (!mem_rsp_valid || mem_rsp_ready) begin
                pick = -1;
                for (i = pend_wait.size() - 1; i >= 0; i--) begin
                    if (pend_wait[i] == 0) begin
                        pick = i;
                    end
                end
                if (pick < 0) begin
                    mem_rsp_valid <= 1'b0;
                end else begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_id    <= pend_id[pick];
                    mem_rsp_data  <= pend_line[pick];
                    pend_id.delete(pick);
                    pend_line.delete(pick);
                    pend_wait.delete(pick);
                end
            end
        end
    end

    initial begin : main
        int         n;
        int         i;
        line_addr_t addr;
        logic       rw;
        clk              = 1'b0;
        seed             = 32'h5a08_7b7d;
        rsp_backpressure = 1'b0;
        next_tag         = '0;
        mem_reads        = 0;
        last_read_addr   = '0;
        arst_n          <= 1'b0;
        core_req_valid  <= 1'b0;
        core_req_rw     <= 1'b0;
        core_req_addr   <= '0;
        core_req_wsel   <= '0;
        core_req_byteen <= '0;
        core_req_data   <= '0;
        core_req_tag    <= '0;
        core_rsp_ready  <= 1'b0;
        mem_req_ready   <= 1'b0;
        mem_rsp_valid   <= 1'b0;
        mem_rsp_id      <= '0;
        mem_rsp_data    <= '0;

        test_name = "reset";
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (!core_rsp_valid && !mem_req_valid)
                else abort_run("a valid output is high during reset");
            end
        end
        arst_n <= 1'b1;
        @(posedge clk);
        assert (!core_rsp_valid && !mem_req_valid)
        else abort_run("a valid output is high on the first cycle after reset");

        test_name = "read miss";
        n = mem_reads;
        send_req(1'b0, 10'h013, 2'd2, 4'h0, '0, free_tag());
        wait_idle(RSP_TIMEOUT);
        assert (mem_reads == n + 1) else report_mismatch("memory reads", n + 1, mem_reads);
        assert (last_read_addr == 10'h013)
        else report_mismatch("memory read address", 10'h013, last_read_addr);

        test_name = "read hit";
        n = mem_reads;
        send_req(1'b0, 10'h013, 2'd0, 4'h0, '0, free_tag());
        wait_idle(RSP_TIMEOUT);
        assert (mem_reads == n) else report_mismatch("memory reads", n, mem_reads);

        test_name = "write hit";
        send_req(1'b1, 10'h013, 2'd2, 4'b0110, 32'h5ac3_96e1, free_tag());
        wait_idle(RSP_TIMEOUT);
        n = mem_reads;
        send_req(1'b0, 10'h013, 2'd2, 4'h0, '0, free_tag());
        wait_idle(RSP_TIMEOUT);
        assert (mem_reads == n) else report_mismatch("memory reads", n, mem_reads);

        test_name = "write miss";
        send_req(1'b1, 10'h2a5, 2'd3, 4'b1001, 32'h7e21_c40b, free_tag());
        wait_idle(RSP_TIMEOUT);
        n = mem_reads;
        send_req(1'b0, 10'h2a5, 2'd3, 4'h0, '0, free_tag());
        wait_idle(RSP_TIMEOUT);
        assert (mem_reads == n + 1) else report_mismatch("memory reads", n + 1, mem_reads);

        // few lines on few indexes, so hits and evictions both show up
        test_name = "random stream";
        rsp_backpressure = 1'b1;
        for (i = 0; i < RANDOM_REQS; i++) begin
            @(negedge clk);
            addr = {4'($unsigned($random(seed)) % 3), 6'($unsigned($random(seed)) % 8)};
            rw   = ($unsigned($random(seed)) % 3) == 0;
            if (rw && line_busy(addr)) begin
                rw = 1'b0;
            end
            send_req(rw, addr, wsel_t'($random(seed)), byteen_t'($random(seed)),
                     word_t'($random(seed)), free_tag());
            if (($unsigned($random(seed)) % 4) == 0) begin
                @(negedge clk);
            end
        end
        wait_idle(DRAIN_TIMEOUT);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/bank_pkg.sv
logic/bank_fifo.sv
logic/bank_tag_store.sv
logic/bank_data_store.sv
logic/bank_mshr.sv
logic/cache_bank.sv
verif/cache_bank_tb.sv
